//--- sources.f
hdl/ifu_pkg.sv
hdl/ifu_fetch_ctrl.sv
hdl/ifu_pc_gen.sv
hdl/ifu_inst_queue.sv
hdl/ifu_top.sv
sim/icache_model.sv
sim/ifu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ifu_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, exit status follows the testbench result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

   // run lengths
   localparam int SEQ_LEN   = 200;
   localparam int STALL_LEN = 120;
   localparam int REDIRECTS = 24;

   // reset, sequential run, stall run, one per redirect
   localparam int NUM_TESTS      = 3 + REDIRECTS;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;

   localparam logic [31:0] SEED = 32'd6694;

   logic clk = 1'b0;
   logic reset;
   logic exu_ifu_stall_req;
   logic redirect;
   ifu_pkg::addr_t redirect_pc;
   logic [1:0] latency;

   wire                  ifu_icu_req_ic1;
   wire ifu_pkg::addr_t  ifu_icu_addr_ic1;
   wire ifu_pkg::inst_t  inst_f;
   wire ifu_pkg::addr_t  pc_out;
   wire                  inst_valid_f;
   wire                  cache_valid;
   wire ifu_pkg::block_t cache_data;
   wire ifu_pkg::addr_t  fill_addr;
   wire ifu_pkg::block_t fill_block;
   wire                  rule_error;

   // expected pc and consume count
   ifu_pkg::addr_t exp_pc;
   int             consumed    = 0;
   int             reset_edges = 0;
   int             error_count = 0;

   // random state and stall window
   logic [31:0] rng;
   logic        stall_on;
   int          stall_left;
   logic        req_prev;

   always #20 clk = ~clk;

   ifu_top DUT (
      .clk                    (clk),
      .reset                  (reset),
      .exu_ifu_stall_req      (exu_ifu_stall_req),
      .redirect               (redirect),
      .redirect_pc            (redirect_pc),
      .icu_ifu_data_ic2       (cache_data),
      .icu_ifu_data_valid_ic2 (cache_valid),
      .ifu_icu_req_ic1        (ifu_icu_req_ic1),
      .ifu_icu_addr_ic1       (ifu_icu_addr_ic1),
      .inst_f                 (inst_f),
      .pc_out                 (pc_out),
      .inst_valid_f           (inst_valid_f));

   icache_model u_icache (
      .clk        (clk),
      .reset      (reset),
      .req        (ifu_icu_req_ic1),
      .addr       (ifu_icu_addr_ic1),
      .latency    (latency),
      .exp_pc     (exp_pc),
      .fill_block (fill_block),
      .fill_addr  (fill_addr),
      .data_valid (cache_valid),
      .data       (cache_data),
      .rule_error (rule_error));

   // instruction word for an address, rotate then scramble
   function automatic ifu_pkg::inst_t mem_word(input ifu_pkg::addr_t a);
      return {a[24:0], a[31:25]} ^ 32'h5a3c_96e1;
   endfunction

   // low half is the word at bit 2 = 0
   assign fill_block = {mem_word(fill_addr + ifu_pkg::INST_BYTES), mem_word(fill_addr)};

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] draw_random();
      rng = xorshift32(rng);
      return rng;
   endfunction

   task automatic stop_on_failure();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic expect_equal(input logic [63:0] got, input logic [63:0] want,
                               input string what);
      if (got !== want) begin
         $display("Mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, want);
         error_count++;
         stop_on_failure();
      end
   endtask

   // one clock, new inputs 2 ns after the edge
   task automatic step();
      @(posedge clk);
      // request of the cycle that just ended
      req_prev = ifu_icu_req_ic1;
      #2;
      redirect = 1'b0;
      latency  = 2'(32'd1 + draw_random() % 32'd3);
      if (!stall_on) begin
         exu_ifu_stall_req = 1'b0;
      end else if (stall_left > 0) begin
         exu_ifu_stall_req = 1'b1;
         stall_left--;
      end else if (draw_random() % 32'd4 == 32'd0) begin
         // window of 1 to 5 cycles
         exu_ifu_stall_req = 1'b1;
         stall_left = int'(draw_random() % 32'd5);
      end else begin
         exu_ifu_stall_req = 1'b0;
      end
   endtask

   // expected pc tracking and output checks
   always @(posedge clk) begin
      if (reset) begin
         exp_pc   <= ifu_pkg::RESET_PC;
         consumed <= 0;
         // first edge only loads the reset values
         if (reset_edges > 0) begin
            expect_equal(64'(inst_valid_f), 64'd0, "inst_valid_f during reset");
            expect_equal(64'(ifu_icu_req_ic1), 64'd0, "cache request during reset");
         end
         reset_edges <= reset_edges + 1;
      end else begin
         if (inst_valid_f) begin
            if (consumed == 0) begin
               expect_equal(64'(pc_out), 64'(ifu_pkg::RESET_PC), "first pc after reset");
            end
            expect_equal(64'(pc_out), 64'(exp_pc), "pc of consumed instruction");
            expect_equal(64'(inst_f), 64'(mem_word(exp_pc)), "consumed instruction word");
            consumed <= consumed + 1;
         end
         if (exu_ifu_stall_req) begin
            expect_equal(64'(inst_valid_f), 64'd0, "inst_valid_f during stall");
         end
         if (redirect) begin
            expect_equal(64'(inst_valid_f), 64'd0, "inst_valid_f during redirect");
         end
         // redirect wins over a consume
         if (redirect) begin
            exp_pc <= redirect_pc;
         end else if (inst_valid_f) begin
            exp_pc <= exp_pc + ifu_pkg::INST_BYTES;
         end
      end
   end

   // protocol breach flagged by the cache model
   always @(posedge clk) begin
      if (rule_error) begin
         $display("Error: the cache model saw a request that breaks the fetch protocol");
         stop_on_failure();
      end
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Error: watchdog expired after %0d cycles, %0d instructions consumed",
               TIMEOUT_CYCLES, consumed);
      stop_on_failure();
   end

   initial begin
      int             goal;
      int             gap;
      logic [31:0]    r;
      ifu_pkg::addr_t target;

      rng               = SEED;
      reset             = 1'b1;
      exu_ifu_stall_req = 1'b0;
      redirect          = 1'b0;
      redirect_pc       = '0;
      latency           = 2'd1;
      stall_on          = 1'b0;
      stall_left        = 0;
      req_prev          = 1'b0;

      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      // straight run, random latency only
      goal = SEQ_LEN;
      while (consumed < goal) begin
         step();
      end

      // stall windows on top
      stall_on = 1'b1;
      goal = consumed + STALL_LEN;
      while (consumed < goal) begin
         step();
      end

      // redirects, odd ones land on an outstanding request
      for (int i = 0; i < REDIRECTS; i++) begin
         if (i % 2 == 1) begin
            do begin
               step();
            end while (!req_prev);
         end else begin
            gap = int'(draw_random() % 32'd8);
            repeat (gap + 1) step();
         end
         r = draw_random();
         target = ifu_pkg::RESET_PC + {20'd0, r[11:3], 3'b000};
         // bit 1 of the count picks the slot
         if (i[1]) begin
            target = target + ifu_pkg::INST_BYTES;
         end
         redirect    = 1'b1;
         redirect_pc = target;
         goal = consumed + 1 + int'(draw_random() % 32'd4);
         while (consumed < goal) begin
            step();
         end
      end

      stall_on = 1'b0;
      repeat (4) step();

      if (error_count == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("Error: %0d checks failed", error_count);
         stop_on_failure();
      end
   end

endmodule

`default_nettype wire

//--- sim/icache_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_model (
   input  wire                  clk,
   input  wire                  reset,

   // request from the fetch unit
   input  wire                  req,
   input  wire ifu_pkg::addr_t  addr,

   // latency picked for a request seen this cycle, 1 to 3
   input  wire [1:0]            latency,

   // pc that the testbench expects the fetch unit to hold
   input  wire ifu_pkg::addr_t  exp_pc,

   // contents of the block at fill_addr
   input  wire ifu_pkg::block_t fill_block,

   output ifu_pkg::addr_t       fill_addr,
   output logic                 data_valid,
   output ifu_pkg::block_t      data,
   output logic                 rule_error
   );

   logic           pending;
   logic [1:0]     wait_cnt;
   ifu_pkg::addr_t pc_block;

   // block of the expected pc, the request may name it or the next one
   assign pc_block = exp_pc & ifu_pkg::BLOCK_MASK;

   // data bus only carries a block on the answer cycle
   assign data = data_valid ? fill_block : '0;

   always @(posedge clk) begin
      if (reset) begin
         pending    <= 1'b0;
         wait_cnt   <= 2'd0;
         data_valid <= 1'b0;
         fill_addr  <= '0;
         rule_error <= 1'b0;
      end else begin
         // answer strobe lasts one cycle
         data_valid <= 1'b0;
         if (req) begin
            if (pending || data_valid) begin
               $display("Error at %0d ns: second cache request before the answer to the first",
                        $time);
               rule_error <= 1'b1;
            end else if (addr[2:0] != 3'b000) begin
               $display("Error at %0d ns: cache request address %h is not 8-byte aligned",
                        $time, addr);
               rule_error <= 1'b1;
            end else if (addr != pc_block && addr != pc_block + ifu_pkg::BLOCK_BYTES) begin
               $display("Error at %0d ns: cache request for %h while the pc is %h",
                        $time, addr, exp_pc);
               rule_error <= 1'b1;
            end
            fill_addr <= addr;
            // one cycle latency answers right on the next cycle
            if (latency <= 2'd1) begin
               data_valid <= 1'b1;
            end else begin
               pending  <= 1'b1;
               wait_cnt <= latency - 2'd1;
            end
         end else if (pending) begin
            if (wait_cnt == 2'd1) begin
               data_valid <= 1'b1;
               pending    <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
   input  wire                  clk,
   input  wire                  reset,

   // execute side
   input  wire                  exu_ifu_stall_req,
   input  wire                  redirect,
   input  wire ifu_pkg::addr_t  redirect_pc,

   // cache answer
   input  wire ifu_pkg::block_t icu_ifu_data_ic2,
   input  wire                  icu_ifu_data_valid_ic2,

   // cache request
   output wire                  ifu_icu_req_ic1,
   output wire ifu_pkg::addr_t  ifu_icu_addr_ic1,

   // to execute
   output wire ifu_pkg::inst_t  inst_f,
   output wire ifu_pkg::addr_t  pc_out,
   output wire                  inst_valid_f
   );

   wire flush_iq;
   wire accepted_valid;
   wire iq_not_empty;
   wire fetch_ahead;

   // request FSM
   ifu_fetch_ctrl u_fetch_ctrl (
      .clk                    (clk),
      .reset                  (reset),
      .redirect               (redirect),
      .iq_not_empty           (iq_not_empty),
      .fetch_ahead            (fetch_ahead),
      .instr_2nd              (pc_out[2]),
      .icu_ifu_data_valid_ic2 (icu_ifu_data_valid_ic2),
      .req_issue              (ifu_icu_req_ic1),
      .flush_iq               (flush_iq),
      .accepted_valid         (accepted_valid));

   // fetch pc and request address
   ifu_pc_gen u_pc_gen (
      .clk              (clk),
      .reset            (reset),
      .redirect         (redirect),
      .redirect_pc      (redirect_pc),
      .inst_valid_f     (inst_valid_f),
      .req_issue        (ifu_icu_req_ic1),
      .iq_not_empty     (iq_not_empty),
      .pc_f             (pc_out),
      .ifu_icu_addr_ic1 (ifu_icu_addr_ic1));

   // one-block queue, fed only by accepted answers
   ifu_inst_queue u_inst_queue (
      .clk                    (clk),
      .reset                  (reset),
      .pc_f                   (pc_out),
      .exu_ifu_stall_req      (exu_ifu_stall_req),
      .flush_iq               (flush_iq),
      .icu_ifu_data_ic2       (icu_ifu_data_ic2),
      .icu_ifu_data_valid_ic2 (accepted_valid),
      .iq_not_empty           (iq_not_empty),
      .fetch_ahead            (fetch_ahead),
      .inst_f                 (inst_f),
      .inst_valid_f           (inst_valid_f));

endmodule

`default_nettype wire

//--- hdl/ifu_inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_inst_queue (
   input  wire                  clk,
   input  wire                  reset,

   input  wire ifu_pkg::addr_t  pc_f,

   input  wire                  exu_ifu_stall_req,
   input  wire                  flush_iq,

   // accepted answer only, stale blocks are already filtered
   input  wire ifu_pkg::block_t icu_ifu_data_ic2,
   input  wire                  icu_ifu_data_valid_ic2,

   output logic                 iq_not_empty,
   output logic                 fetch_ahead,
   output ifu_pkg::inst_t       inst_f,
   output logic                 inst_valid_f
   );

   logic            instr_2nd;
   logic            iq_not_empty_q;
   logic            stalled_q;
   logic            inst_present;
   ifu_pkg::block_t inst_rdata_q;
   ifu_pkg::block_t inst_data;

   // slot select
   assign instr_2nd = pc_f[2];

   // not-empty flag
   // set when a block lands with pc in the first slot
   // cleared once pc sits in the second slot, or on a flush
   always_ff @(posedge clk) begin
      if (reset) begin
         iq_not_empty_q <= 1'b0;
      end else if (instr_2nd | icu_ifu_data_valid_ic2 | flush_iq) begin
         iq_not_empty_q <= ~instr_2nd & ~flush_iq;
      end
   end

   // something for the current pc, fresh or stored
   assign inst_present = icu_ifu_data_valid_ic2 | iq_not_empty_q | stalled_q;

   // stalled flag
   // keeps an instruction alive while execute holds it off,
   // covers the second slot that the not-empty flag drops
   always_ff @(posedge clk) begin
      if (reset) begin
         stalled_q <= 1'b0;
      end else begin
         stalled_q <= exu_ifu_stall_req & inst_present & ~flush_iq;
      end
   end

   // block register, payload only
   always_ff @(posedge clk) begin
      if (icu_ifu_data_valid_ic2) begin
         inst_rdata_q <= icu_ifu_data_ic2;
      end
   end

   // bypass the arriving block in its own cycle
   assign inst_data = icu_ifu_data_valid_ic2 ? icu_ifu_data_ic2 : inst_rdata_q;

   // pc bit 2 picks the half
   assign inst_f = instr_2nd ? inst_data[63:32] : inst_data[31:0];

   // consumed whenever high
   assign inst_valid_f = inst_present & ~exu_ifu_stall_req & ~flush_iq;

   assign iq_not_empty = inst_present & ~flush_iq;

   // stored block in use and moving
   assign fetch_ahead = (iq_not_empty_q | stalled_q) & ~exu_ifu_stall_req & ~flush_iq;

   // controller only refills an empty queue,
   // so a new block never lands on a pending instruction
   assert property (@(posedge clk) disable iff (reset)
      icu_ifu_data_valid_ic2 |-> !(iq_not_empty_q || stalled_q))
      else $error("fetch block arrived while the queue still held one");

endmodule

`default_nettype wire

//--- hdl/ifu_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_gen (
   input  wire                 clk,
   input  wire                 reset,

   // execute side redirect
   input  wire                 redirect,
   input  wire ifu_pkg::addr_t redirect_pc,

   // consume strobe from the queue
   input  wire                 inst_valid_f,

   // request strobe and queue occupancy
   input  wire                 req_issue,
   input  wire                 iq_not_empty,

   output ifu_pkg::addr_t      pc_f,
   output ifu_pkg::addr_t      ifu_icu_addr_ic1
   );

   ifu_pkg::addr_t pc_block;
   ifu_pkg::addr_t next_block;
   ifu_pkg::addr_t req_addr;

   // fetch pc
   // redirect wins over a consume
   // a stall keeps inst_valid_f low, so pc holds
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_f <= ifu_pkg::RESET_PC;
      end else if (redirect) begin
         pc_f <= redirect_pc;
      end else if (inst_valid_f) begin
         pc_f <= pc_f + ifu_pkg::INST_BYTES;
      end
   end

   // block holding the current pc
   assign pc_block = pc_f & ifu_pkg::BLOCK_MASK;

   // block after it
   assign next_block = pc_block + ifu_pkg::BLOCK_BYTES;

   // empty queue fetches the block of pc itself
   // otherwise the last slot is leaving now, so fetch ahead
   assign req_addr = iq_not_empty ? next_block : pc_block;

   // address bus parked at zero between requests
   assign ifu_icu_addr_ic1 = req_issue ? req_addr : '0;

   // execute side only jumps to word boundaries
   assert property (@(posedge clk) disable iff (reset)
      redirect |-> (redirect_pc[1:0] == 2'b00))
      else $error("redirect target is not word aligned");

endmodule

`default_nettype wire

//--- hdl/ifu_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_ctrl (
   input  wire  clk,
   input  wire  reset,

   // execute side redirect strobe
   input  wire  redirect,

   // queue status
   input  wire  iq_not_empty,
   input  wire  fetch_ahead,
   input  wire  instr_2nd,

   // raw answer strobe from the cache
   input  wire  icu_ifu_data_valid_ic2,

   output logic req_issue,
   output logic flush_iq,
   output logic accepted_valid
   );

   ifu_pkg::fetch_state_t state;
   ifu_pkg::fetch_state_t state_nxt;

   logic queue_dry;
   logic answer_live;

   // queue holds nothing at all,
   // or the second slot of the stored block leaves this cycle
   // so the next block is needed right after
   assign queue_dry = ~iq_not_empty | (fetch_ahead & instr_2nd);

   // request only from REQ, never on a redirect cycle
   // since pc is about to jump and the address would be stale
   assign req_issue = (state == ifu_pkg::REQ) & queue_dry & ~redirect;

   // redirect flushes the queue on the same cycle
   assign flush_iq = redirect;

   // answer belongs to the current pc only in WAIT
   assign answer_live = (state == ifu_pkg::WAIT) & ~redirect;

   // stale or dropped answers never reach the queue
   assign accepted_valid = icu_ifu_data_valid_ic2 & answer_live;

   always_comb begin
      state_nxt = state;
      case (state)
         ifu_pkg::IDLE: begin
            // first request one cycle after reset
            state_nxt = ifu_pkg::REQ;
         end
         ifu_pkg::REQ: begin
            // hold here until the queue is about to run dry
            if (req_issue) begin
               state_nxt = ifu_pkg::WAIT;
            end
         end
         ifu_pkg::WAIT: begin
            if (icu_ifu_data_valid_ic2) begin
               // answer taken, or swallowed if redirect hits the same cycle
               state_nxt = ifu_pkg::REQ;
            end else if (redirect) begin
               state_nxt = ifu_pkg::DROP;
            end
         end
         ifu_pkg::DROP: begin
            // throw the old block away, then fetch the redirect target
            if (icu_ifu_data_valid_ic2) begin
               state_nxt = ifu_pkg::REQ;
            end
         end
         default: begin
            state_nxt = ifu_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ifu_pkg::IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // one request in flight at most
   // a new request never meets an answer still coming back
   assert property (@(posedge clk) disable iff (reset)
      req_issue |-> !icu_ifu_data_valid_ic2)
      else $error("fetch request issued while an answer is outstanding");

   // cache never answers without a request
   assert property (@(posedge clk) disable iff (reset)
      (state == ifu_pkg::IDLE) |-> !icu_ifu_data_valid_ic2)
      else $error("cache answer arrived with no request outstanding");

endmodule

`default_nettype wire

//--- hdl/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

   // widths of the fetch datapath
   localparam int ADDR_W  = 32;
   localparam int INST_W  = 32;
   localparam int BLOCK_W = 2 * INST_W;

   // byte address
   typedef logic [ADDR_W-1:0] addr_t;

   // one instruction word
   typedef logic [INST_W-1:0] inst_t;

   // one cache block, two instructions
   // low half sits at address bit 2 = 0
   typedef logic [BLOCK_W-1:0] block_t;

   // boot address
   localparam addr_t RESET_PC = 32'h1c00_0000;

   // pc step per instruction
   localparam addr_t INST_BYTES = 32'd4;

   // bytes per fetch block
   localparam addr_t BLOCK_BYTES = 32'd8;

   // clears the offset inside a block
   localparam addr_t BLOCK_MASK = ~(BLOCK_BYTES - 32'd1);

   // fetch controller states
   // IDLE  out of reset only
   // REQ   waiting to issue, fires when the queue runs dry
   // WAIT  one request outstanding
   // DROP  outstanding answer is stale after a redirect
   typedef enum logic [1:0] {
      IDLE = 2'd0,
      REQ  = 2'd1,
      WAIT = 2'd2,
      DROP = 2'd3
   } fetch_state_t;

endpackage

`default_nettype wire
